// File: source/game_view_defs.svh
`ifndef GAME_VIEW_DEFS_SVH
`define GAME_VIEW_DEFS_SVH

// screen geometry
`define SCREEN_W 320
`define SCREEN_H 240
`define X_W 9
`define Y_W 8
`define COLOR_W 12

// sprites
`define SPRITE_SIZE 20
`define CORNER 4

// object table, 20-bit words
`define OBJ_COUNT 16
`define OBJ_ADDR_W 4
`define OBJ_W 20
`define OBJ_X_LSB 11
`define OBJ_Y_LSB 3
`define OBJ_KIND_LSB 1
`define OBJ_VIS_BIT 0

// first row of ground
`define GROUND_Y 80

// palette, 4 bits per channel
`define SKY_COLOR 12'h6CF
`define GROUND_COLOR 12'h852
`define GOLD_COLOR 12'hFD0
`define STONE_COLOR 12'h888
`define DIAMOND_COLOR 12'h0EF
`define DIAMOND_EDGE_COLOR 12'hFFF

`endif

// File: source/game_view_pkg.sv
package game_view_pkg;

	// kind field of a table word; empty also marks the background job
	typedef enum logic [1:0] {
		kind_empty,
		kind_gold,
		kind_stone,
		kind_diamond
	} obj_kind_t;

	// frame sequencer states
	typedef enum logic [2:0] {
		st_idle,
		st_background,
		st_fetch,
		st_issue,
		st_wait_job,
		st_drain
	} seq_state_t;

endpackage

// File: source/object_table.sv
`include "game_view_defs.svh"

module object_table (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   wr,
	input  logic [`OBJ_ADDR_W-1:0] wr_addr,
	input  logic [`OBJ_W-1:0]      wr_data,
	input  logic [`OBJ_ADDR_W-1:0] rd_addr,
	output logic [`OBJ_W-1:0]      rd_data
);

	logic [`OBJ_W-1:0] mem [`OBJ_COUNT];

	// all-zero word decodes as an empty, invisible entry
	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < `OBJ_COUNT; i++) begin
				mem[i] <= '0;
			end
		end else if (wr) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// one cycle read latency
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: source/frame_sequencer.sv
`include "game_view_defs.svh"

module frame_sequencer import game_view_pkg::*; (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   go,
	input  logic [`OBJ_W-1:0]      rd_data,
	input  logic                   job_done,
	input  logic                   frame_done,
	output logic                   busy,
	output logic [`OBJ_ADDR_W-1:0] rd_addr,
	output logic                   job_start,
	output logic [`X_W-1:0]        job_x,
	output logic [`Y_W-1:0]        job_y,
	output logic [`X_W-1:0]        job_w,
	output logic [`Y_W-1:0]        job_h,
	output obj_kind_t              job_kind,
	output logic                   job_visible,
	output logic                   job_frame_last
);

	seq_state_t state;
	logic [`OBJ_ADDR_W-1:0] cur_idx;
	logic [`OBJ_ADDR_W-1:0] scan_prev;
	logic [`OBJ_ADDR_W-1:0] last_idx;
	logic scan_live;
	logic any_obj;
	logic outstanding;
	logic scan_hit;
	logic bg_issue;
	logic obj_issue;
	obj_kind_t rd_kind;

	assign rd_addr = cur_idx;
	assign rd_kind = obj_kind_t'(rd_data[`OBJ_KIND_LSB +: 2]);

	// the background state also scans the table for the last non-empty entry
	assign scan_hit = scan_live && (rd_kind != kind_empty);
	assign bg_issue = (state == st_background) && scan_live &&
		(scan_prev == `OBJ_ADDR_W'(`OBJ_COUNT - 1));
	assign obj_issue = (state == st_issue) && (rd_kind != kind_empty);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= st_idle;
			busy <= 1'b0;
			job_start <= 1'b0;
			job_frame_last <= 1'b0;
			cur_idx <= '0;
			scan_prev <= '0;
			last_idx <= '0;
			scan_live <= 1'b0;
			any_obj <= 1'b0;
		end else begin
			job_start <= 1'b0;
			case (state)
				st_idle: begin
					if (go) begin
						state <= st_background;
						busy <= 1'b1;
						cur_idx <= '0;
						scan_live <= 1'b0;
						any_obj <= 1'b0;
						last_idx <= '0;
					end
				end
				st_background: begin
					scan_prev <= cur_idx;
					scan_live <= 1'b1;
					if (scan_hit) begin
						last_idx <= scan_prev;
						any_obj <= 1'b1;
					end
					if (bg_issue) begin
						// cur_idx has wrapped back to entry 0 here
						job_start <= 1'b1;
						job_frame_last <= !(any_obj || scan_hit);
						state <= st_wait_job;
					end else begin
						cur_idx <= cur_idx + 1'b1;
					end
				end
				st_fetch: begin
					state <= st_issue;
				end
				st_issue: begin
					cur_idx <= cur_idx + 1'b1;
					if (obj_issue) begin
						job_start <= 1'b1;
						job_frame_last <= (cur_idx == last_idx);
						state <= st_wait_job;
					end else begin
						state <= st_fetch;
					end
				end
				st_wait_job: begin
					if (job_done) begin
						state <= job_frame_last ? st_drain : st_fetch;
					end
				end
				st_drain: begin
					// last pixels still in the shader and filter
					if (frame_done) begin
						state <= st_idle;
						busy <= 1'b0;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (bg_issue) begin
			job_x <= '0;
			job_y <= '0;
			job_w <= `X_W'(`SCREEN_W);
			job_h <= `Y_W'(`SCREEN_H);
			job_kind <= kind_empty;
			job_visible <= 1'b1;
		end else if (obj_issue) begin
			job_x <= rd_data[`OBJ_X_LSB +: `X_W];
			job_y <= rd_data[`OBJ_Y_LSB +: `Y_W];
			job_w <= `X_W'(`SPRITE_SIZE);
			job_h <= `Y_W'(`SPRITE_SIZE);
			job_kind <= rd_kind;
			job_visible <= rd_data[`OBJ_VIS_BIT];
		end
	end

	// a job is outstanding from its start until the scanner reports it done
	always_ff @(posedge clk) begin
		if (!resetn) begin
			outstanding <= 1'b0;
		end else if (job_start) begin
			outstanding <= 1'b1;
		end else if (job_done) begin
			outstanding <= 1'b0;
		end
	end

	a_one_job: assert property (@(posedge clk) disable iff (!resetn)
		job_start |-> !outstanding);

endmodule

// File: source/pixel_scanner.sv
`include "game_view_defs.svh"

module pixel_scanner import game_view_pkg::*; (
	input  logic            clk,
	input  logic            resetn,
	input  logic            job_start,
	input  logic [`X_W-1:0] job_x,
	input  logic [`Y_W-1:0] job_y,
	input  logic [`X_W-1:0] job_w,
	input  logic [`Y_W-1:0] job_h,
	input  obj_kind_t       job_kind,
	input  logic            job_visible,
	input  logic            job_frame_last,
	output logic            job_done,
	output logic            pix_valid,
	output logic [`X_W-1:0] pix_x,
	output logic [`Y_W-1:0] pix_y,
	output logic [`X_W-1:0] pix_dx,
	output logic [`Y_W-1:0] pix_dy,
	output obj_kind_t       pix_kind,
	output logic            pix_visible,
	output logic            pix_last
);

	logic [`X_W-1:0] base_x;
	logic [`X_W-1:0] last_dx;
	logic [`Y_W-1:0] last_dy;
	logic frame_last;
	logic row_end;

	assign row_end = (pix_dx == last_dx);
	assign job_done = pix_valid && row_end && (pix_dy == last_dy);
	assign pix_last = job_done && frame_last;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pix_valid <= 1'b0;
		end else if (job_start) begin
			pix_valid <= 1'b1;
		end else if (job_done) begin
			pix_valid <= 1'b0;
		end
	end

	// latch the job, then walk row-major one pixel per cycle
	always_ff @(posedge clk) begin
		if (job_start) begin
			base_x <= job_x;
			last_dx <= job_w - 1'b1;
			last_dy <= job_h - 1'b1;
			pix_x <= job_x;
			pix_y <= job_y;
			pix_dx <= '0;
			pix_dy <= '0;
			pix_kind <= job_kind;
			pix_visible <= job_visible;
			frame_last <= job_frame_last;
		end else if (pix_valid) begin
			if (row_end) begin
				pix_dx <= '0;
				pix_x <= base_x;
				pix_dy <= pix_dy + 1'b1;
				pix_y <= pix_y + 1'b1;
			end else begin
				pix_dx <= pix_dx + 1'b1;
				pix_x <= pix_x + 1'b1;
			end
		end
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (!resetn)
		job_start |-> !pix_valid);

endmodule

// File: source/sprite_shader.sv
`include "game_view_defs.svh"

module sprite_shader import game_view_pkg::*; (
	input  logic                clk,
	input  logic                resetn,
	input  logic                pix_valid,
	input  logic [`X_W-1:0]     pix_x,
	input  logic [`Y_W-1:0]     pix_y,
	input  logic [`X_W-1:0]     pix_dx,
	input  logic [`Y_W-1:0]     pix_dy,
	input  obj_kind_t           pix_kind,
	input  logic                pix_visible,
	input  logic                pix_last,
	output logic                shd_valid,
	output logic [`X_W-1:0]     shd_x,
	output logic [`Y_W-1:0]     shd_y,
	output logic [`COLOR_W-1:0] shd_color,
	output logic                shd_visible,
	output logic                shd_last
);

	logic dx_band;
	logic dy_band;
	logic [`X_W:0] diag;
	logic [`COLOR_W-1:0] color;

	// corner squares are where both offsets sit in an edge band
	assign dx_band = (pix_dx < `X_W'(`CORNER)) ||
		(pix_dx >= `X_W'(`SPRITE_SIZE - `CORNER));
	assign dy_band = (pix_dy < `Y_W'(`CORNER)) ||
		(pix_dy >= `Y_W'(`SPRITE_SIZE - `CORNER));

	// diagonal stripes on diamonds
	assign diag = {1'b0, pix_dx} + {{(`X_W - `Y_W + 1){1'b0}}, pix_dy};

	always_comb begin
		color = '0;
		case (pix_kind)
			kind_empty: color = (pix_y < `Y_W'(`GROUND_Y)) ? `SKY_COLOR : `GROUND_COLOR;
			kind_gold: if (!(dx_band && dy_band)) color = `GOLD_COLOR;
			kind_stone: if (!(dx_band && dy_band)) color = `STONE_COLOR;
			kind_diamond: begin
				if (!(dx_band && dy_band)) begin
					color = diag[2] ? `DIAMOND_EDGE_COLOR : `DIAMOND_COLOR;
				end
			end
			default: color = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			shd_valid <= 1'b0;
			shd_last <= 1'b0;
		end else begin
			shd_valid <= pix_valid;
			shd_last <= pix_last;
		end
	end

	always_ff @(posedge clk) begin
		shd_x <= pix_x;
		shd_y <= pix_y;
		shd_color <= color;
		shd_visible <= pix_visible;
	end

endmodule

// File: source/write_filter.sv
`include "game_view_defs.svh"

module write_filter (
	input  logic                clk,
	input  logic                resetn,
	input  logic                shd_valid,
	input  logic [`X_W-1:0]     shd_x,
	input  logic [`Y_W-1:0]     shd_y,
	input  logic [`COLOR_W-1:0] shd_color,
	input  logic                shd_visible,
	input  logic                shd_last,
	output logic [`X_W-1:0]     x_out,
	output logic [`Y_W-1:0]     y_out,
	output logic [`COLOR_W-1:0] color_out,
	output logic                write_en,
	output logic                frame_done
);

	// transparent and hidden pixels still advance, they just never write
	always_ff @(posedge clk) begin
		if (!resetn) begin
			write_en <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			write_en <= shd_valid && shd_visible && (shd_color != '0);
			frame_done <= shd_valid && shd_last;
		end
	end

	always_ff @(posedge clk) begin
		if (shd_valid) begin
			x_out <= shd_x;
			y_out <= shd_y;
			color_out <= shd_color;
		end
	end

	a_no_blank_write: assert property (@(posedge clk) disable iff (!resetn)
		write_en |-> (color_out != '0));

endmodule

// File: source/game_view.sv
`include "game_view_defs.svh"

module game_view import game_view_pkg::*; (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   go,
	input  logic                   obj_wr,
	input  logic [`OBJ_ADDR_W-1:0] obj_addr,
	input  logic [`OBJ_W-1:0]      obj_data,
	output logic [`X_W-1:0]        x_out,
	output logic [`Y_W-1:0]        y_out,
	output logic [`COLOR_W-1:0]    color_out,
	output logic                   write_en,
	output logic                   busy,
	output logic                   frame_done
);

	logic [`OBJ_ADDR_W-1:0] rd_addr;
	logic [`OBJ_W-1:0] rd_data;

	// sequencer to scanner
	logic job_start;
	logic job_done;
	logic [`X_W-1:0] job_x;
	logic [`Y_W-1:0] job_y;
	logic [`X_W-1:0] job_w;
	logic [`Y_W-1:0] job_h;
	obj_kind_t job_kind;
	logic job_visible;
	logic job_frame_last;

	// scanner to shader
	logic pix_valid;
	logic [`X_W-1:0] pix_x;
	logic [`Y_W-1:0] pix_y;
	logic [`X_W-1:0] pix_dx;
	logic [`Y_W-1:0] pix_dy;
	obj_kind_t pix_kind;
	logic pix_visible;
	logic pix_last;

	// shader to filter
	logic shd_valid;
	logic [`X_W-1:0] shd_x;
	logic [`Y_W-1:0] shd_y;
	logic [`COLOR_W-1:0] shd_color;
	logic shd_visible;
	logic shd_last;

	object_table u_table (
		.clk(clk), .resetn(resetn), .wr(obj_wr), .wr_addr(obj_addr),
		.wr_data(obj_data), .rd_addr(rd_addr), .rd_data(rd_data)
	);

	frame_sequencer u_seq (
		.clk(clk), .resetn(resetn), .go(go), .rd_data(rd_data),
		.job_done(job_done), .frame_done(frame_done), .busy(busy),
		.rd_addr(rd_addr), .job_start(job_start), .job_x(job_x), .job_y(job_y),
		.job_w(job_w), .job_h(job_h), .job_kind(job_kind),
		.job_visible(job_visible), .job_frame_last(job_frame_last)
	);

	pixel_scanner u_scan (
		.clk(clk), .resetn(resetn), .job_start(job_start), .job_x(job_x),
		.job_y(job_y), .job_w(job_w), .job_h(job_h), .job_kind(job_kind),
		.job_visible(job_visible), .job_frame_last(job_frame_last),
		.job_done(job_done), .pix_valid(pix_valid), .pix_x(pix_x), .pix_y(pix_y),
		.pix_dx(pix_dx), .pix_dy(pix_dy), .pix_kind(pix_kind),
		.pix_visible(pix_visible), .pix_last(pix_last)
	);

	sprite_shader u_shade (
		.clk(clk), .resetn(resetn), .pix_valid(pix_valid), .pix_x(pix_x),
		.pix_y(pix_y), .pix_dx(pix_dx), .pix_dy(pix_dy), .pix_kind(pix_kind),
		.pix_visible(pix_visible), .pix_last(pix_last), .shd_valid(shd_valid),
		.shd_x(shd_x), .shd_y(shd_y), .shd_color(shd_color),
		.shd_visible(shd_visible), .shd_last(shd_last)
	);

	write_filter u_filter (
		.clk(clk), .resetn(resetn), .shd_valid(shd_valid), .shd_x(shd_x),
		.shd_y(shd_y), .shd_color(shd_color), .shd_visible(shd_visible),
		.shd_last(shd_last), .x_out(x_out), .y_out(y_out),
		.color_out(color_out), .write_en(write_en), .frame_done(frame_done)
	);

endmodule

// File: tb/tb_clock.sv
module tb_clock (
	output logic clk,
	output logic resetn
);

	// period of 8
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held low for 8 cycles, released on a falling edge
	initial begin
		resetn = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
	end

endmodule

// File: tb/game_view_tb.sv
`include "game_view_defs.svh"

module game_view_tb import game_view_pkg::*;;

	localparam int NUM_FRAMES = 5;
	localparam longint FRAME_CYCLES = `SCREEN_W * `SCREEN_H +
		`OBJ_COUNT * (`SPRITE_SIZE * `SPRITE_SIZE + 4);

	logic clk;
	logic resetn;
	logic go;
	logic obj_wr;
	logic [`OBJ_ADDR_W-1:0] obj_addr;
	logic [`OBJ_W-1:0] obj_data;
	logic [`X_W-1:0] x_out;
	logic [`Y_W-1:0] y_out;
	logic [`COLOR_W-1:0] color_out;
	logic write_en;
	logic busy;
	logic frame_done;

	integer seed = 7673;
	int tab_x [`OBJ_COUNT];
	int tab_y [`OBJ_COUNT];
	obj_kind_t tab_kind [`OBJ_COUNT];
	logic tab_vis [`OBJ_COUNT];
	// expected writes as {x, y, color}
	logic [28:0] exp_q [$];
	int done_count;
	int write_count;

	tb_clock u_clock (.clk(clk), .resetn(resetn));

	game_view uut (
		.clk(clk), .resetn(resetn), .go(go), .obj_wr(obj_wr), .obj_addr(obj_addr),
		.obj_data(obj_data), .x_out(x_out), .y_out(y_out), .color_out(color_out),
		.write_en(write_en), .busy(busy), .frame_done(frame_done)
	);

	task automatic check_value(input string what, input int actual, input int expected);
		if (actual != expected) begin
			$display("Error at time %0t: %s is %0d, expected %0d", $time, what, actual,
				expected);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// reference write sequence for the current table
	task automatic build_expected();
		logic [`COLOR_W-1:0] c;
		logic in_corner;
		int px;
		int py;
		exp_q.delete();
		for (int y = 0; y < `SCREEN_H; y++) begin
			for (int x = 0; x < `SCREEN_W; x++) begin
				c = (y < `GROUND_Y) ? `SKY_COLOR : `GROUND_COLOR;
				exp_q.push_back({x[8:0], y[7:0], c});
			end
		end
		for (int i = 0; i < `OBJ_COUNT; i++) begin
			if (tab_kind[i] != kind_empty && tab_vis[i]) begin
				for (int dy = 0; dy < `SPRITE_SIZE; dy++) begin
					for (int dx = 0; dx < `SPRITE_SIZE; dx++) begin
						in_corner = (dx < `CORNER || dx >= `SPRITE_SIZE - `CORNER) &&
							(dy < `CORNER || dy >= `SPRITE_SIZE - `CORNER);
						if (!in_corner) begin
							case (tab_kind[i])
								kind_gold: c = `GOLD_COLOR;
								kind_stone: c = `STONE_COLOR;
								default: c = ((dx + dy) & 4) ? `DIAMOND_EDGE_COLOR : `DIAMOND_COLOR;
							endcase
							px = tab_x[i] + dx;
							py = tab_y[i] + dy;
							exp_q.push_back({px[8:0], py[7:0], c});
						end
					end
				end
			end
		end
	endtask

	task automatic load_random_table();
		for (int i = 0; i < `OBJ_COUNT; i++) begin
			tab_kind[i] = obj_kind_t'($random(seed) & 3);
			tab_vis[i] = $random(seed) & 1;
			tab_x[i] = $unsigned($random(seed)) % 301;
			tab_y[i] = `GROUND_Y + $unsigned($random(seed)) % 141;
			@(negedge clk);
			obj_wr = 1'b1;
			obj_addr = i[`OBJ_ADDR_W-1:0];
			obj_data = {tab_x[i][8:0], tab_y[i][7:0], tab_kind[i], tab_vis[i]};
		end
		@(negedge clk);
		obj_wr = 1'b0;
	endtask

	// one frame, with an optional go while busy
	task automatic draw_frame(input bit extra_go);
		done_count = 0;
		write_count = 0;
		@(negedge clk);
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;
		check_value("busy after go", busy, 1);
		if (extra_go) begin
			repeat (50) @(negedge clk);
			go = 1'b1;
			@(negedge clk);
			go = 1'b0;
		end
		while (!frame_done) @(negedge clk);
		@(negedge clk);
		check_value("busy after frame_done", busy, 0);
		repeat (40) @(negedge clk);
		check_value("frame_done pulses", done_count, 1);
		check_value("missing writes", exp_q.size(), 0);
	endtask

	// outputs compared on the falling edge, where they are stable
	always @(negedge clk) begin
		logic [28:0] e;
		if (resetn) begin
			if (write_en) begin
				if (exp_q.size() == 0) begin
					$display("write_en was high at time %0t with no write left to expect", $time);
					$display("Verification failed");
					$fatal(1);
				end else begin
					e = exp_q.pop_front();
					write_count++;
					check_value("x_out", x_out, e[28:20]);
					check_value("y_out", y_out, e[19:12]);
					check_value("color_out", color_out, e[11:0]);
				end
			end
			if (frame_done) begin
				// the final pixel's output cycle, so every write is already out
				check_value("writes left at frame_done", exp_q.size(), 0);
				done_count++;
			end
		end
	end

	initial begin
		#(NUM_FRAMES * FRAME_CYCLES * 8 * 2);
		$display("the frame never finished before the watchdog ran out at time %0t", $time);
		$display("Verification failed");
		$fatal(1);
	end

	initial begin
		go = 1'b0;
		obj_wr = 1'b0;
		obj_addr = '0;
		obj_data = '0;
		for (int i = 0; i < `OBJ_COUNT; i++) begin
			tab_kind[i] = kind_empty;
			tab_vis[i] = 1'b0;
			tab_x[i] = 0;
			tab_y[i] = 0;
		end
		wait (resetn);
		@(negedge clk);
		check_value("write_en after reset", write_en, 0);
		check_value("busy after reset", busy, 0);
		check_value("frame_done after reset", frame_done, 0);
		// table is cleared by reset, so the first frame is background only
		build_expected();
		draw_frame(1'b0);
		check_value("background writes", write_count, `SCREEN_W * `SCREEN_H);
		for (int f = 1; f < NUM_FRAMES; f++) begin
			load_random_table();
			build_expected();
			draw_frame(f == 2);
		end
		$display("Verification passed");
		$finish;
	end

endmodule

// File: build.f
+incdir+source
source/game_view_pkg.sv
source/object_table.sv
source/frame_sequencer.sv
source/pixel_scanner.sv
source/sprite_shader.sv
source/write_filter.sv
source/game_view.sv
tb/tb_clock.sv
tb/game_view_tb.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f build.f --top-module game_view_tb -Mdir obj_dir; then
	echo "compile failed"
	exit 1
fi

out=$(./obj_dir/Vgame_view_tb 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Verification passed"; then
	exit 0
fi
exit 1
